/* mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data word width
`define XLEN 32

// HI and LO side by side
`define HILO_W 64

// Return address skips the delay slot
`define LINK_OFFSET 8

// Relative branches count from the delay slot
`define DELAY_SLOT_OFFSET 4

`endif

/* codes.sv */
`include "mips_params.svh"

package codes;

  typedef logic [`XLEN-1:0]   size_t;
  typedef logic [`HILO_W-1:0] hilo_t;
  typedef logic [5:0]         opcode_t;
  typedef logic [5:0]         func_t;
  typedef logic [4:0]         regimm_t;
  typedef logic [4:0]         shamt_t;
  typedef logic [15:0]        imm16_t;
  typedef logic [25:0]        target26_t;

  // Primary opcodes, instruction bits 31:26
  localparam opcode_t OP_SPECIAL = 6'h00;
  localparam opcode_t OP_REGIMM  = 6'h01;
  localparam opcode_t OP_J       = 6'h02;
  localparam opcode_t OP_JAL     = 6'h03;
  localparam opcode_t OP_BEQ     = 6'h04;
  localparam opcode_t OP_BNE     = 6'h05;
  localparam opcode_t OP_BLEZ    = 6'h06;
  localparam opcode_t OP_BGTZ    = 6'h07;
  localparam opcode_t OP_ADDI    = 6'h08;
  localparam opcode_t OP_ADDIU   = 6'h09;
  localparam opcode_t OP_SLTI    = 6'h0a;
  localparam opcode_t OP_SLTIU   = 6'h0b;
  localparam opcode_t OP_ANDI    = 6'h0c;
  localparam opcode_t OP_ORI     = 6'h0d;
  localparam opcode_t OP_XORI    = 6'h0e;
  localparam opcode_t OP_LUI     = 6'h0f;
  localparam opcode_t OP_LB      = 6'h20;
  localparam opcode_t OP_LH      = 6'h21;
  localparam opcode_t OP_LW      = 6'h23;
  localparam opcode_t OP_SB      = 6'h28;
  localparam opcode_t OP_SH      = 6'h29;
  localparam opcode_t OP_SW      = 6'h2b;

  // SPECIAL function codes, bits 5:0
  localparam func_t FUNC_SLL   = 6'h00;
  localparam func_t FUNC_SRL   = 6'h02;
  localparam func_t FUNC_SRA   = 6'h03;
  localparam func_t FUNC_SLLV  = 6'h04;
  localparam func_t FUNC_SRLV  = 6'h06;
  localparam func_t FUNC_SRAV  = 6'h07;
  localparam func_t FUNC_JR    = 6'h08;
  localparam func_t FUNC_JALR  = 6'h09;
  localparam func_t FUNC_MTHI  = 6'h11;
  localparam func_t FUNC_MTLO  = 6'h13;
  localparam func_t FUNC_MULT  = 6'h18;
  localparam func_t FUNC_MULTU = 6'h19;
  localparam func_t FUNC_DIV   = 6'h1a;
  localparam func_t FUNC_DIVU  = 6'h1b;
  localparam func_t FUNC_ADD   = 6'h20;
  localparam func_t FUNC_ADDU  = 6'h21;
  localparam func_t FUNC_SUB   = 6'h22;
  localparam func_t FUNC_SUBU  = 6'h23;
  localparam func_t FUNC_AND   = 6'h24;
  localparam func_t FUNC_OR    = 6'h25;
  localparam func_t FUNC_XOR   = 6'h26;
  localparam func_t FUNC_NOR   = 6'h27;
  localparam func_t FUNC_SLT   = 6'h2a;
  localparam func_t FUNC_SLTU  = 6'h2b;

  // REGIMM selectors, carried in the rt field
  localparam regimm_t REGIMM_BLTZ   = 5'h00;
  localparam regimm_t REGIMM_BGEZ   = 5'h01;
  localparam regimm_t REGIMM_BLTZAL = 5'h10;
  localparam regimm_t REGIMM_BGEZAL = 5'h11;

endpackage

/* instr_decode.sv */
module instr_decode import codes::*; (
  input  size_t     instr_i,
  output opcode_t   opcode_o,
  output func_t     funct_o,
  output regimm_t   regimm_o,
  output shamt_t    shamt_o,
  output imm16_t    immediate_o,
  output target26_t target_o
);

  // Common to all three formats
  assign opcode_o = instr_i[31:26];

  // R format
  assign funct_o = instr_i[5:0];
  assign shamt_o = instr_i[10:6];

  // REGIMM branches reuse the rt slot as a selector
  assign regimm_o = instr_i[20:16];

  // I format
  assign immediate_o = instr_i[15:0];

  // J format
  assign target_o = instr_i[25:0];

  // Every downstream case statement keys on the opcode
  always_comb begin
    assert (!$isunknown(opcode_o))
      else $error("instr_decode: opcode field is unknown");
  end

endmodule

/* hilo_unit.sv */
`include "mips_params.svh"

module hilo_unit import codes::*; (
  input  logic  clk,
  input  logic  reset_i,
  input  logic  hilo_en_i,
  input  func_t funct_i,
  input  size_t rs_i,
  input  size_t rt_i,
  output size_t mfhi_o,
  output size_t mflo_o
);

  hilo_t prod_s;
  hilo_t prod_u;
  size_t quo_s;
  size_t rem_s;
  size_t quo_u;
  size_t rem_u;
  logic  div_zero;
  size_t hi_q;
  size_t lo_q;

  // Sign or zero extend to full width, low 64 bits of the product are exact
  assign prod_s = {{`XLEN{rs_i[`XLEN-1]}}, rs_i} * {{`XLEN{rt_i[`XLEN-1]}}, rt_i};
  assign prod_u = {{`XLEN{1'b0}}, rs_i} * {{`XLEN{1'b0}}, rt_i};

  assign div_zero = (rt_i == '0);

  // Quotient goes to LO, remainder to HI
  assign quo_s = div_zero ? '0 : size_t'($signed(rs_i) / $signed(rt_i));
  assign rem_s = div_zero ? '0 : size_t'($signed(rs_i) % $signed(rt_i));
  assign quo_u = div_zero ? '0 : rs_i / rt_i;
  assign rem_u = div_zero ? '0 : rs_i % rt_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      hi_q <= '0;
      lo_q <= '0;
    end else if (hilo_en_i) begin
      case (funct_i)
        FUNC_MULT:  {hi_q, lo_q} <= prod_s;
        FUNC_MULTU: {hi_q, lo_q} <= prod_u;
        FUNC_DIV: begin
          hi_q <= rem_s;
          lo_q <= quo_s;
        end
        FUNC_DIVU: begin
          hi_q <= rem_u;
          lo_q <= quo_u;
        end
        // Moves touch only their own half
        FUNC_MTHI: hi_q <= rs_i;
        FUNC_MTLO: lo_q <= rs_i;
        default: ;
      endcase
    end
  end

  assign mfhi_o = hi_q;
  assign mflo_o = lo_q;

  // Nothing issued alongside reset may leak into HI/LO
  a_hilo_cleared: assert property (@(posedge clk) reset_i |=> (mfhi_o == '0 && mflo_o == '0))
    else $error("hilo_unit: HI/LO not cleared after reset");

endmodule

/* branch_unit.sv */
`include "mips_params.svh"

module branch_unit import codes::*; (
  input  opcode_t   opcode_i,
  input  func_t     funct_i,
  input  regimm_t   regimm_i,
  input  size_t     rs_i,
  input  size_t     rt_i,
  input  imm16_t    immediate_i,
  input  target26_t target_i,
  input  size_t     pc_i,
  output logic      b_cond_met_o,
  output size_t     target_addr_o,
  output size_t     link_value_o,
  output logic      is_flow_o,
  output logic      is_link_o
);

  size_t imm_sext;
  size_t rel_target;
  size_t jump_target;
  logic  rs_neg;
  logic  rs_zero;
  logic  is_rel;

  assign imm_sext = {{(`XLEN-16){immediate_i[15]}}, immediate_i};
  assign rs_neg   = rs_i[`XLEN-1];
  assign rs_zero  = (rs_i == '0);

  // Word offset counted from the delay slot
  assign rel_target = pc_i + size_t'(`DELAY_SLOT_OFFSET) + (imm_sext << 2);

  // Stays inside the current 256 MB region
  assign jump_target = {pc_i[`XLEN-1:`XLEN-4], target_i, 2'b00};

  assign link_value_o = pc_i + size_t'(`LINK_OFFSET);

  always_comb begin
    b_cond_met_o  = 1'b0;
    target_addr_o = '0;
    is_flow_o     = 1'b0;
    is_link_o     = 1'b0;
    is_rel        = 1'b0;
    case (opcode_i)
      OP_BEQ: begin
        is_rel       = 1'b1;
        b_cond_met_o = (rs_i == rt_i);
      end
      OP_BNE: begin
        is_rel       = 1'b1;
        b_cond_met_o = (rs_i != rt_i);
      end
      OP_BGTZ: begin
        is_rel       = 1'b1;
        b_cond_met_o = !rs_neg && !rs_zero;
      end
      OP_BLEZ: begin
        is_rel       = 1'b1;
        b_cond_met_o = rs_neg || rs_zero;
      end
      OP_REGIMM: begin
        case (regimm_i)
          REGIMM_BLTZ, REGIMM_BLTZAL: begin
            is_rel       = 1'b1;
            b_cond_met_o = rs_neg;
          end
          REGIMM_BGEZ, REGIMM_BGEZAL: begin
            is_rel       = 1'b1;
            b_cond_met_o = !rs_neg;
          end
          default: ;
        endcase
        // Link is written even when the branch falls through
        is_link_o = (regimm_i == REGIMM_BLTZAL) || (regimm_i == REGIMM_BGEZAL);
      end
      OP_J, OP_JAL: begin
        is_flow_o     = 1'b1;
        b_cond_met_o  = 1'b1;
        target_addr_o = jump_target;
        is_link_o     = (opcode_i == OP_JAL);
      end
      OP_SPECIAL: begin
        if (funct_i == FUNC_JR || funct_i == FUNC_JALR) begin
          is_flow_o     = 1'b1;
          b_cond_met_o  = 1'b1;
          target_addr_o = rs_i;
          is_link_o     = (funct_i == FUNC_JALR);
        end
      end
      default: ;
    endcase
    if (is_rel) begin
      is_flow_o     = 1'b1;
      target_addr_o = rel_target;
    end
    // The fetch stage only redirects on flow instructions
    assert (!b_cond_met_o || is_flow_o)
      else $error("branch_unit: taken flag without a flow instruction");
  end

endmodule

/* alu.sv */
`include "mips_params.svh"

module alu import codes::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  opcode_t   opcode_i,
  input  func_t     funct_i,
  input  regimm_t   regimm_i,
  input  shamt_t    shamt_i,
  input  imm16_t    immediate_i,
  input  target26_t target_i,
  input  size_t     rs_i,
  input  size_t     rt_i,
  input  size_t     pc_i,
  input  size_t     ram_readdata_i,
  output size_t     rd_o,
  output size_t     rt_o,
  output size_t     effective_address_o,
  output logic      b_cond_met_o,
  output size_t     mfhi_o,
  output size_t     mflo_o
);

  size_t imm_sext;
  size_t imm_zext;
  size_t ls_addr;
  size_t r_result;
  size_t i_result;
  logic  is_mem;
  logic  hilo_en;
  size_t target_addr;
  size_t link_value;
  logic  is_flow;
  logic  is_link;

  assign imm_sext = {{(`XLEN-16){immediate_i[15]}}, immediate_i};
  assign imm_zext = {{(`XLEN-16){1'b0}}, immediate_i};
  assign ls_addr  = rs_i + imm_sext;
  assign hilo_en  = (opcode_i == OP_SPECIAL);

  hilo_unit u_hilo (
    .clk       (clk),
    .reset_i   (reset_i),
    .hilo_en_i (hilo_en),
    .funct_i   (funct_i),
    .rs_i      (rs_i),
    .rt_i      (rt_i),
    .mfhi_o    (mfhi_o),
    .mflo_o    (mflo_o)
  );

  branch_unit u_branch (
    .opcode_i      (opcode_i),
    .funct_i       (funct_i),
    .regimm_i      (regimm_i),
    .rs_i          (rs_i),
    .rt_i          (rt_i),
    .immediate_i   (immediate_i),
    .target_i      (target_i),
    .pc_i          (pc_i),
    .b_cond_met_o  (b_cond_met_o),
    .target_addr_o (target_addr),
    .link_value_o  (link_value),
    .is_flow_o     (is_flow),
    .is_link_o     (is_link)
  );

  // R-type results, written to rd
  always_comb begin
    r_result = '0;
    if (opcode_i == OP_SPECIAL) begin
      case (funct_i)
        FUNC_SLL:  r_result = rt_i << shamt_i;
        FUNC_SRL:  r_result = rt_i >> shamt_i;
        FUNC_SRA:  r_result = size_t'($signed(rt_i) >>> shamt_i);
        FUNC_SLLV: r_result = rt_i << rs_i[4:0];
        FUNC_SRLV: r_result = rt_i >> rs_i[4:0];
        FUNC_SRAV: r_result = size_t'($signed(rt_i) >>> rs_i[4:0]);
        // No overflow trap, ADD and SUB wrap like their unsigned forms
        FUNC_ADD, FUNC_ADDU: r_result = rs_i + rt_i;
        FUNC_SUB, FUNC_SUBU: r_result = rs_i - rt_i;
        FUNC_AND:  r_result = rs_i & rt_i;
        FUNC_OR:   r_result = rs_i | rt_i;
        FUNC_XOR:  r_result = rs_i ^ rt_i;
        FUNC_NOR:  r_result = ~(rs_i | rt_i);
        FUNC_SLT:  r_result = {{(`XLEN-1){1'b0}}, $signed(rs_i) < $signed(rt_i)};
        FUNC_SLTU: r_result = {{(`XLEN-1){1'b0}}, rs_i < rt_i};
        default:   r_result = '0;
      endcase
    end
  end

  // Immediate ops, loads and stores, written to rt
  always_comb begin
    i_result = '0;
    is_mem   = 1'b0;
    case (opcode_i)
      OP_ADDI, OP_ADDIU: i_result = rs_i + imm_sext;
      OP_SLTI:  i_result = {{(`XLEN-1){1'b0}}, $signed(rs_i) < $signed(imm_sext)};
      // Unsigned compare, but the immediate is still sign extended
      OP_SLTIU: i_result = {{(`XLEN-1){1'b0}}, rs_i < imm_sext};
      OP_ANDI:  i_result = rs_i & imm_zext;
      OP_ORI:   i_result = rs_i | imm_zext;
      OP_XORI:  i_result = rs_i ^ imm_zext;
      OP_LUI:   i_result = {immediate_i, {(`XLEN-16){1'b0}}};
      // Sub-word data sits left justified in the RAM word
      OP_LW, OP_LH, OP_LB: begin
        is_mem = 1'b1;
        if (opcode_i == OP_LW) begin
          i_result = ram_readdata_i;
        end else if (opcode_i == OP_LH) begin
          i_result = ram_readdata_i >> (`XLEN - 16);
        end else begin
          i_result = ram_readdata_i >> (`XLEN - 8);
        end
      end
      OP_SW, OP_SH, OP_SB: begin
        is_mem = 1'b1;
        if (opcode_i == OP_SW) begin
          i_result = rt_i;
        end else if (opcode_i == OP_SH) begin
          i_result = rt_i << (`XLEN - 16);
        end else begin
          i_result = rt_i << (`XLEN - 8);
        end
      end
      default: ;
    endcase
  end

  assign rt_o = i_result;

  // Link forms overwrite rd with the return address
  assign rd_o = is_link ? link_value : r_result;

  // Flow target wins, otherwise the memory address, otherwise nothing
  assign effective_address_o = is_flow ? target_addr : (is_mem ? ls_addr : '0);

endmodule

/* exec_stage.sv */
module exec_stage import codes::*; (
  input  logic  clk,
  input  logic  reset_i,
  input  size_t instr_i,
  input  size_t rs_i,
  input  size_t rt_i,
  input  size_t pc_i,
  input  size_t ram_readdata_i,
  output size_t rd_o,
  output size_t rt_o,
  output size_t effective_address_o,
  output logic  b_cond_met_o,
  output size_t mfhi_o,
  output size_t mflo_o
);

  opcode_t   opcode;
  func_t     funct;
  regimm_t   regimm;
  shamt_t    shamt;
  imm16_t    immediate;
  target26_t target;

  instr_decode u_decode (
    .instr_i     (instr_i),
    .opcode_o    (opcode),
    .funct_o     (funct),
    .regimm_o    (regimm),
    .shamt_o     (shamt),
    .immediate_o (immediate),
    .target_o    (target)
  );

  alu u_alu (
    .clk                 (clk),
    .reset_i             (reset_i),
    .opcode_i            (opcode),
    .funct_i             (funct),
    .regimm_i            (regimm),
    .shamt_i             (shamt),
    .immediate_i         (immediate),
    .target_i            (target),
    .rs_i                (rs_i),
    .rt_i                (rt_i),
    .pc_i                (pc_i),
    .ram_readdata_i      (ram_readdata_i),
    .rd_o                (rd_o),
    .rt_o                (rt_o),
    .effective_address_o (effective_address_o),
    .b_cond_met_o        (b_cond_met_o),
    .mfhi_o              (mfhi_o),
    .mflo_o              (mflo_o)
  );

endmodule

/* tb_exec_stage.sv */
`include "mips_params.svh"

module tb_exec_stage import codes::*; ();

  // One cycle per instruction across the R-type, immediate, branch, HI/LO and reset tests
  localparam int TEST_CYCLES   = 16 * 6 + 14 * 4 + 12 * 4 + (4 * 4 + 4) + 4;
  localparam int WATCHDOG_TIME = (TEST_CYCLES + 3 + 40) * 8;

  logic  clk;
  logic  reset_i;
  size_t instr_i;
  size_t rs_i;
  size_t rt_i;
  size_t pc_i;
  size_t ram_readdata_i;
  size_t rd_o;
  size_t rt_o;
  size_t effective_address_o;
  logic  b_cond_met_o;
  size_t mfhi_o;
  size_t mflo_o;

  logic [31:0] lfsr_state;
  size_t       exp_hi;
  size_t       exp_lo;
  int          errors;

  exec_stage dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("TB FAILED");
    $finish;
  end

  // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic size_t rand_bits(input int n);
    size_t val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic size_t rand_word();
    return rand_bits(32);
  endfunction

  function automatic size_t r_format(input func_t fn, input shamt_t sh);
    return {OP_SPECIAL, 5'd1, 5'd2, 5'd3, sh, fn};
  endfunction

  function automatic size_t i_format(input opcode_t op, input regimm_t rt_sel, input imm16_t imm);
    return {op, 5'd1, rt_sel, imm};
  endfunction

  function automatic size_t j_format(input opcode_t op, input target26_t tgt);
    return {op, tgt};
  endfunction

  // Expected combinational outputs of one instruction
  task automatic model_exec(input size_t instr, input size_t rs, input size_t rt,
                            input size_t pc, input size_t ram, output size_t e_rd,
                            output size_t e_rt, output size_t e_ea, output logic e_flag);
    opcode_t op;
    func_t   fn;
    regimm_t sel;
    shamt_t  sh;
    size_t   sext;
    size_t   zext;
    size_t   link;
    op     = instr[31:26];
    fn     = instr[5:0];
    sel    = instr[20:16];
    sh     = instr[10:6];
    sext   = size_t'($signed(instr[15:0]));
    zext   = size_t'(instr[15:0]);
    link   = pc + `LINK_OFFSET;
    e_rd   = '0;
    e_rt   = '0;
    e_ea   = '0;
    e_flag = 1'b0;
    case (op)
      OP_SPECIAL: begin
        case (fn)
          FUNC_SLL:  e_rd = rt << sh;
          FUNC_SRL:  e_rd = rt >> sh;
          FUNC_SRA:  e_rd = size_t'($signed(rt) >>> sh);
          FUNC_SLLV: e_rd = rt << rs[4:0];
          FUNC_SRLV: e_rd = rt >> rs[4:0];
          FUNC_SRAV: e_rd = size_t'($signed(rt) >>> rs[4:0]);
          FUNC_ADD, FUNC_ADDU: e_rd = rs + rt;
          FUNC_SUB, FUNC_SUBU: e_rd = rs - rt;
          FUNC_AND:  e_rd = rs & rt;
          FUNC_OR:   e_rd = rs | rt;
          FUNC_XOR:  e_rd = rs ^ rt;
          FUNC_NOR:  e_rd = ~(rs | rt);
          FUNC_SLT:  e_rd = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
          FUNC_SLTU: e_rd = (rs < rt) ? 32'd1 : 32'd0;
          FUNC_JR, FUNC_JALR: begin
            e_flag = 1'b1;
            e_ea   = rs;
            if (fn == FUNC_JALR) e_rd = link;
          end
          default: ;
        endcase
      end
      OP_J, OP_JAL: begin
        e_flag = 1'b1;
        e_ea   = {pc[31:28], instr[25:0], 2'b00};
        if (op == OP_JAL) e_rd = link;
      end
      OP_BEQ:  e_flag = (rs == rt);
      OP_BNE:  e_flag = (rs != rt);
      OP_BGTZ: e_flag = ($signed(rs) > 0);
      OP_BLEZ: e_flag = ($signed(rs) <= 0);
      OP_REGIMM: begin
        if (sel == REGIMM_BGEZ || sel == REGIMM_BGEZAL) e_flag = ($signed(rs) >= 0);
        else e_flag = ($signed(rs) < 0);
        if (sel == REGIMM_BLTZAL || sel == REGIMM_BGEZAL) e_rd = link;
      end
      OP_ADDI, OP_ADDIU: e_rt = rs + sext;
      OP_SLTI:  e_rt = ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
      OP_SLTIU: e_rt = (rs < sext) ? 32'd1 : 32'd0;
      OP_ANDI:  e_rt = rs & zext;
      OP_ORI:   e_rt = rs | zext;
      OP_XORI:  e_rt = rs ^ zext;
      OP_LUI:   e_rt = zext << 16;
      // Sub-word data is left justified
      OP_LW:    e_rt = ram;
      OP_LH:    e_rt = ram >> 16;
      OP_LB:    e_rt = ram >> 24;
      OP_SW:    e_rt = rt;
      OP_SH:    e_rt = rt << 16;
      OP_SB:    e_rt = rt << 24;
      default: ;
    endcase
    if (op inside {OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_REGIMM})
      e_ea = pc + `DELAY_SLOT_OFFSET + (sext << 2);
    if (op inside {OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB}) e_ea = rs + sext;
  endtask

  // HI/LO as they will be after the next rising edge
  task automatic update_hilo(input size_t instr, input size_t rs, input size_t rt);
    if (instr[31:26] == OP_SPECIAL) begin
      case (func_t'(instr[5:0]))
        FUNC_MULT:  {exp_hi, exp_lo} = hilo_t'(longint'($signed(rs)) * longint'($signed(rt)));
        FUNC_MULTU: {exp_hi, exp_lo} = hilo_t'(rs) * hilo_t'(rt);
        FUNC_DIV: begin
          exp_lo = (rt == '0) ? '0 : size_t'(longint'($signed(rs)) / longint'($signed(rt)));
          exp_hi = (rt == '0) ? '0 : size_t'(longint'($signed(rs)) % longint'($signed(rt)));
        end
        FUNC_DIVU: begin
          exp_lo = (rt == '0) ? '0 : rs / rt;
          exp_hi = (rt == '0) ? '0 : rs % rt;
        end
        FUNC_MTHI: exp_hi = rs;
        FUNC_MTLO: exp_lo = rs;
        default: ;
      endcase
    end
  endtask

  task automatic check_word(input string name, input size_t expected, input size_t actual);
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // One instruction per cycle, sampled just before the next edge
  task automatic run_instr(input size_t instr, input size_t rs, input size_t rt,
                           input size_t pc, input size_t ram);
    size_t e_rd;
    size_t e_rt;
    size_t e_ea;
    logic  e_flag;
    @(posedge clk);
    #1;
    instr_i        = instr;
    rs_i           = rs;
    rt_i           = rt;
    pc_i           = pc;
    ram_readdata_i = ram;
    #6;
    model_exec(instr, rs, rt, pc, ram, e_rd, e_rt, e_ea, e_flag);
    check_word("rd_o", e_rd, rd_o);
    check_word("rt_o", e_rt, rt_o);
    check_word("effective_address_o", e_ea, effective_address_o);
    check_flag("b_cond_met_o", e_flag, b_cond_met_o);
    check_word("mfhi_o", exp_hi, mfhi_o);
    check_word("mflo_o", exp_lo, mflo_o);
    update_hilo(instr, rs, rt);
  endtask

  task automatic test_rtype();
    func_t  fns [16];
    size_t  rs;
    size_t  rt;
    shamt_t sh;
    fns = '{FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV, FUNC_SRLV, FUNC_SRAV, FUNC_ADD, FUNC_ADDU,
            FUNC_SUB, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR, FUNC_SLT, FUNC_SLTU};
    foreach (fns[i]) begin
      for (int k = 0; k < 6; k++) begin
        rs = rand_word();
        rt = rand_word();
        sh = shamt_t'(rand_bits(5));
        // Shift by 0 and by 31, then equal operands
        if (k == 0) begin
          sh      = 5'd0;
          rs[4:0] = 5'd0;
        end
        if (k == 1) begin
          sh      = 5'd31;
          rs[4:0] = 5'd31;
        end
        if (k == 2) rt = rs;
        run_instr(r_format(fns[i], sh), rs, rt, rand_word(), rand_word());
      end
    end
  endtask

  task automatic test_itype();
    opcode_t ops [14];
    imm16_t  imm;
    size_t   rs;
    size_t   rt;
    size_t   ram;
    ops = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
            OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB};
    foreach (ops[i]) begin
      for (int k = 0; k < 4; k++) begin
        rs  = rand_word();
        rt  = rand_word();
        ram = rand_word();
        imm = imm16_t'(rand_bits(16));
        if (k == 0) imm = 16'h8000;
        if (k == 1) imm = 16'hffff;
        if (k == 2) imm = 16'h0004;
        run_instr(i_format(ops[i], 5'd2, imm), rs, rt, rand_word(), ram);
      end
    end
  endtask

  task automatic test_branch();
    size_t  instr;
    size_t  rs;
    size_t  rt;
    size_t  pc;
    imm16_t imm;
    for (int f = 0; f < 12; f++) begin
      for (int k = 0; k < 4; k++) begin
        rs  = rand_word();
        rt  = rand_word();
        pc  = rand_word() & ~32'h3;
        imm = imm16_t'(rand_bits(16));
        // Equal operands, zero, negative and positive rs
        case (k)
          0: rt = rs;
          1: rs = '0;
          2: rs[31] = 1'b1;
          default: rs[31] = 1'b0;
        endcase
        case (f)
          0: instr = i_format(OP_BEQ, 5'd2, imm);
          1: instr = i_format(OP_BNE, 5'd2, imm);
          2: instr = i_format(OP_BLEZ, 5'd0, imm);
          3: instr = i_format(OP_BGTZ, 5'd0, imm);
          4: instr = i_format(OP_REGIMM, REGIMM_BLTZ, imm);
          5: instr = i_format(OP_REGIMM, REGIMM_BGEZ, imm);
          6: instr = i_format(OP_REGIMM, REGIMM_BLTZAL, imm);
          7: instr = i_format(OP_REGIMM, REGIMM_BGEZAL, imm);
          8: instr = j_format(OP_J, target26_t'(rand_bits(26)));
          9: instr = j_format(OP_JAL, target26_t'(rand_bits(26)));
          10: instr = r_format(FUNC_JR, 5'd0);
          default: instr = r_format(FUNC_JALR, 5'd0);
        endcase
        run_instr(instr, rs, rt, pc, rand_word());
      end
    end
  endtask

  task automatic test_hilo();
    func_t fns [4];
    size_t rs;
    size_t rt;
    fns = '{FUNC_MULT, FUNC_MULTU, FUNC_DIV, FUNC_DIVU};
    foreach (fns[i]) begin
      for (int k = 0; k < 4; k++) begin
        rs = rand_word();
        rt = rand_word() >> 8;
        if (k < 2) rs[31] = 1'b1;
        if (k == 1) rt = ~rt;
        if (k == 3) rt = '0;
        run_instr(r_format(fns[i], 5'd0), rs, rt, '0, '0);
      end
    end
    // Odd operands leave LO nonzero ahead of the moves
    run_instr(r_format(FUNC_MULTU, 5'd0), rand_word() | 32'h1, rand_word() | 32'h1, '0, '0);
    run_instr(r_format(FUNC_MTHI, 5'd0), rand_word(), rand_word(), '0, '0);
    run_instr(r_format(FUNC_MTLO, 5'd0), rand_word(), rand_word(), '0, '0);
    run_instr(r_format(FUNC_SLL, 5'd0), '0, '0, '0, '0);
  endtask

  task automatic test_reset();
    run_instr(r_format(FUNC_MULT, 5'd0), rand_word(), rand_word(), '0, '0);
    run_instr(r_format(FUNC_SLL, 5'd0), '0, '0, '0, '0);
    // A multiply presented together with reset must not reach HI/LO
    @(posedge clk);
    #1;
    reset_i = 1'b1;
    instr_i = r_format(FUNC_MULTU, 5'd0);
    rs_i    = rand_word();
    rt_i    = rand_word();
    @(posedge clk);
    #1;
    reset_i = 1'b0;
    instr_i = r_format(FUNC_SLL, 5'd0);
    exp_hi  = '0;
    exp_lo  = '0;
    #6;
    check_word("mfhi_o", exp_hi, mfhi_o);
    check_word("mflo_o", exp_lo, mflo_o);
  endtask

  initial begin
    lfsr_state     = 32'h719e7ff3;
    errors         = 0;
    exp_hi         = '0;
    exp_lo         = '0;
    reset_i        = 1'b1;
    instr_i        = '0;
    rs_i           = '0;
    rt_i           = '0;
    pc_i           = '0;
    ram_readdata_i = '0;
    repeat (3) @(posedge clk);
    #1;
    reset_i = 1'b0;
    test_rtype();
    test_itype();
    test_branch();
    test_hilo();
    test_reset();
    $display("exec_stage checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+.
codes.sv
instr_decode.sv
hilo_unit.sv
branch_unit.sv
alu.sv
exec_stage.sv
tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the exec_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_exec_stage -o sim_exec_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_exec_stage)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
